/* logic/decode_pkg.sv */
`default_nettype none

package decode_pkg;

  parameter int XLEN        = 32;
  parameter int REG_NO_BITS = 5;
  parameter int ALU_OP_BITS = 4;

  // reserved register numbers for the coprocessor port
  parameter logic [REG_NO_BITS-1:0] DEF_ALUOP_REG   = 5'd27;
  parameter logic [REG_NO_BITS-1:0] DEF_OP1_REG     = 5'd28;
  parameter logic [REG_NO_BITS-1:0] DEF_OP2_REG     = 5'd29;
  parameter logic [REG_NO_BITS-1:0] DEF_OP3_REG     = 5'd30;
  parameter logic [REG_NO_BITS-1:0] DEF_CSR_OUT_REG = 5'd31;

  //////////////////////////////
  // enums

  typedef enum logic [5:0] {
    IOP_INVALID, // zero, so a bubble decodes as invalid
    IOP_ADD, IOP_SUB, IOP_AND, IOP_OR, IOP_XOR,
    IOP_SLT, IOP_SLTU, IOP_SRA, IOP_SRL, IOP_SLL,
    IOP_ADDI, IOP_ANDI, IOP_ORI, IOP_XORI, IOP_SLTI,
    IOP_SLTIU, IOP_SRAI, IOP_SRLI, IOP_SLLI,
    IOP_LUI, IOP_AUIPC, IOP_LW, IOP_SW, IOP_JAL, IOP_JALR,
    IOP_BEQ, IOP_BNE, IOP_BLT, IOP_BGE, IOP_BLTU, IOP_BGEU
  } iop_e;

  typedef enum logic [2:0] {INST_NONE, INST_R, INST_I, INST_S, INST_U} inst_type_e;

  typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;

  // numbering as seen by the coprocessor, cpu side has mul/div swapped
  typedef enum logic [ALU_OP_BITS-1:0] {
    ALU_NONE = 4'd0,
    ALU_DIV  = 4'd1,
    ALU_MUL  = 4'd2
  } alu_op_e;

  //////////////////////////////
  // stage interfaces

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
  } fe_latch_t;

  typedef struct packed {
    logic                   wr_reg;
    logic [REG_NO_BITS-1:0] wregno;
    logic [XLEN-1:0]        regval;
  } wb_t;

  typedef struct packed {
    iop_e                   op;
    logic [REG_NO_BITS-1:0] rs1;
    logic [REG_NO_BITS-1:0] rs2;
    logic [REG_NO_BITS-1:0] rd;
    logic [XLEN-1:0]        imm;
    logic                   use_rs1;
    logic                   use_rs2;
    logic                   is_br;
    logic                   is_jmp;
    logic                   rd_mem;
    logic                   wr_mem;
    logic                   wr_reg;
  } dec_info_t;

  typedef struct packed {
    logic                   valid;
    logic [XLEN-1:0]        inst;
    logic [XLEN-1:0]        pc;
    iop_e                   op;
    logic [XLEN-1:0]        rs1_val;
    logic [XLEN-1:0]        rs2_val;
    logic [XLEN-1:0]        imm;
    logic                   is_br;
    logic                   is_jmp;
    logic                   rd_mem;
    logic                   wr_mem;
    logic                   wr_reg;
    logic [REG_NO_BITS-1:0] rd;
  } de_latch_t;

  typedef struct packed {
    logic [2:0]      csr_out; // [0] op1 taken, [1] op2 taken
    logic [XLEN-1:0] op3;
  } fu_to_de_t;

  typedef struct packed {
    logic [2:0]      csr_in; // [0] result consumed, [1] op1 stable, [2] op2 stable
    alu_op_e         aluop;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] op1;
  } de_to_fu_t;

endpackage

`default_nettype wire

/* logic/inst_decoder.sv */
`default_nettype none

module inst_decoder import decode_pkg::*; (
  input  fe_latch_t fe,
  output dec_info_t info
);

  // rv32i major opcodes of the kept instructions
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } rv_opc_e;

  logic [XLEN-1:0] inst;
  logic [6:0]      opc;
  logic [2:0]      f3;
  logic [6:0]      f7;
  iop_e            op;
  inst_type_e      itype;
  imm_type_e       imm_type;
  logic            writes_rd;

  assign inst = fe.inst;
  assign opc  = inst[6:0];
  assign f3   = inst[14:12];
  assign f7   = inst[31:25];

  always_comb begin
    op = IOP_INVALID;
    case (opc)
      OPC_OP: begin
        if (f7 == 7'b0000000) begin
          case (f3)
            3'b000: op = IOP_ADD;
            3'b001: op = IOP_SLL;
            3'b010: op = IOP_SLT;
            3'b011: op = IOP_SLTU;
            3'b100: op = IOP_XOR;
            3'b101: op = IOP_SRL;
            3'b110: op = IOP_OR;
            default: op = IOP_AND;
          endcase
        end else if (f7 == 7'b0100000) begin
          if (f3 == 3'b000) op = IOP_SUB;
          else if (f3 == 3'b101) op = IOP_SRA;
        end // mul and friends stay invalid
      end
      OPC_OP_IMM: begin
        case (f3)
          3'b000: op = IOP_ADDI;
          3'b010: op = IOP_SLTI;
          3'b011: op = IOP_SLTIU;
          3'b100: op = IOP_XORI;
          3'b110: op = IOP_ORI;
          3'b111: op = IOP_ANDI;
          3'b001: if (f7 == 7'b0000000) op = IOP_SLLI;
          default: begin
            if (f7 == 7'b0000000) op = IOP_SRLI;
            else if (f7 == 7'b0100000) op = IOP_SRAI;
          end
        endcase
      end
      OPC_LUI:   op = IOP_LUI;
      OPC_AUIPC: op = IOP_AUIPC;
      OPC_LOAD:  if (f3 == 3'b010) op = IOP_LW;
      OPC_STORE: if (f3 == 3'b010) op = IOP_SW;
      OPC_JAL:   op = IOP_JAL;
      OPC_JALR:  if (f3 == 3'b000) op = IOP_JALR;
      OPC_BRANCH: begin
        case (f3)
          3'b000: op = IOP_BEQ;
          3'b001: op = IOP_BNE;
          3'b100: op = IOP_BLT;
          3'b101: op = IOP_BGE;
          3'b110: op = IOP_BLTU;
          3'b111: op = IOP_BGEU;
          default: op = IOP_INVALID;
        endcase
      end
      default: op = IOP_INVALID; // csr access lands here too
    endcase
    if (!fe.valid) op = IOP_INVALID;
  end

  // format and immediate type
  always_comb begin
    itype    = INST_NONE;
    imm_type = IMM_NONE;
    case (op)
      IOP_ADD, IOP_SUB, IOP_AND, IOP_OR, IOP_XOR,
      IOP_SLT, IOP_SLTU, IOP_SRA, IOP_SRL, IOP_SLL: itype = INST_R;
      IOP_ADDI, IOP_ANDI, IOP_ORI, IOP_XORI, IOP_SLTI, IOP_SLTIU,
      IOP_SRAI, IOP_SRLI, IOP_SLLI, IOP_LW, IOP_JALR: begin
        itype    = INST_I;
        imm_type = IMM_I;
      end
      IOP_LUI, IOP_AUIPC: begin
        itype    = INST_U;
        imm_type = IMM_U;
      end
      IOP_JAL: begin
        itype    = INST_U;
        imm_type = IMM_J;
      end
      IOP_SW: begin
        itype    = INST_S;
        imm_type = IMM_S;
      end
      IOP_BEQ, IOP_BNE, IOP_BLT, IOP_BGE, IOP_BLTU, IOP_BGEU: begin
        itype    = INST_S; // two sources like a store
        imm_type = IMM_B;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (imm_type)
      IMM_I:   info.imm = {{20{inst[31]}}, inst[31:20]};
      IMM_S:   info.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      IMM_B:   info.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      IMM_U:   info.imm = {inst[31:12], 12'b0};
      IMM_J:   info.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: info.imm = '0;
    endcase
  end

  assign writes_rd = !(op inside {IOP_INVALID, IOP_SW, IOP_BEQ, IOP_BNE,
                                  IOP_BLT, IOP_BGE, IOP_BLTU, IOP_BGEU});

  assign info.op      = op;
  assign info.rs1     = inst[19:15];
  assign info.rs2     = inst[24:20];
  assign info.rd      = inst[11:7];
  assign info.use_rs1 = itype inside {INST_R, INST_I, INST_S};
  assign info.use_rs2 = itype inside {INST_R, INST_S};
  assign info.is_br   = op inside {IOP_BEQ, IOP_BNE, IOP_BLT, IOP_BGE, IOP_BLTU, IOP_BGEU};
  assign info.is_jmp  = op inside {IOP_JAL, IOP_JALR};
  assign info.rd_mem  = (op == IOP_LW);
  assign info.wr_mem  = (op == IOP_SW);
  assign info.wr_reg  = writes_rd && (info.rd != '0); // x0 writes are dropped

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file import decode_pkg::*; (
  input  logic                   clk,
  input  wb_t                    wb,
  input  logic [REG_NO_BITS-1:0] rs1,
  input  logic [REG_NO_BITS-1:0] rs2,
  output logic [XLEN-1:0]        rs1_val,
  output logic [XLEN-1:0]        rs2_val
);

  logic [XLEN-1:0] regs [32];
  logic            wr_en;

  initial begin
    for (int i = 0; i < 32; i++) regs[i] = '0;
  end

  assign wr_en = wb.wr_reg && (wb.wregno != '0); // x0 stays zero

  always @(posedge clk) begin
    if (wr_en) regs[wb.wregno] <= wb.regval;
  end

  // write-through, a same-cycle wb shows up on the read ports
  assign rs1_val = (wr_en && (wb.wregno == rs1)) ? wb.regval : regs[rs1];
  assign rs2_val = (wr_en && (wb.wregno == rs2)) ? wb.regval : regs[rs2];

endmodule

`default_nettype wire

/* logic/scoreboard.sv */
`default_nettype none

module scoreboard import decode_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  dec_info_t info,
  input  logic      wr_reg,  // write-enable after coprocessor suppression
  input  logic      issue,
  input  wb_t       wb,
  output logic      hazard
);

  logic [31:0] busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wb.wr_reg) busy[wb.wregno] <= 1'b0;
      // set after clear, a new writer of the same register wins
      if (issue && wr_reg) busy[info.rd] <= 1'b1;
    end
  end

  assign hazard = (info.use_rs1 && busy[info.rs1]) ||
                  (info.use_rs2 && busy[info.rs2]);

  a_x0_never_busy: assert property (@(posedge clk) disable iff (reset) !busy[0])
    else $error("scoreboard marked x0 busy");

endmodule

`default_nettype wire

/* logic/alu_port.sv */
`default_nettype none

module alu_port import decode_pkg::*; #(
  parameter logic [REG_NO_BITS-1:0] ALUOP_REG   = DEF_ALUOP_REG,
  parameter logic [REG_NO_BITS-1:0] OP1_REG     = DEF_OP1_REG,
  parameter logic [REG_NO_BITS-1:0] OP2_REG     = DEF_OP2_REG,
  parameter logic [REG_NO_BITS-1:0] OP3_REG     = DEF_OP3_REG,
  parameter logic [REG_NO_BITS-1:0] CSR_OUT_REG = DEF_CSR_OUT_REG
) (
  input  logic            clk,
  input  logic            reset,
  input  dec_info_t       info,
  input  logic            issue,
  input  logic [XLEN-1:0] rs2_val,
  input  fu_to_de_t       fu_in,
  output de_to_fu_t       fu_out,
  output logic [XLEN-1:0] rs2_val_final,
  output logic            wr_reg_final
);

  logic is_lw;
  logic is_sw;
  logic load_aluop;
  logic load_op1;
  logic load_op2;
  logic store_op3;
  logic store_csr;

  // op is invalid for an empty fetch slot, so no valid term needed
  assign is_lw      = (info.op == IOP_LW);
  assign is_sw      = (info.op == IOP_SW);
  assign load_aluop = is_lw && (info.rd == ALUOP_REG);
  assign load_op1   = is_lw && (info.rd == OP1_REG);
  assign load_op2   = is_lw && (info.rd == OP2_REG);
  assign store_op3  = is_sw && (info.rs2 == OP3_REG);
  assign store_csr  = is_sw && (info.rs2 == CSR_OUT_REG);

  //////////////////////////////
  // store data and write-enable

  always_comb begin
    if (store_op3) rs2_val_final = fu_in.op3;
    else if (store_csr) rs2_val_final = {{(XLEN-3){1'b0}}, fu_in.csr_out};
    else rs2_val_final = rs2_val;
  end

  assign wr_reg_final = info.wr_reg && !(load_aluop || load_op1 || load_op2);

  //////////////////////////////
  // operand registers and handshake

  always_ff @(posedge clk) begin
    if (reset) begin
      fu_out <= '0;
    end else begin
      if (issue && load_aluop) begin
        case (rs2_val[ALU_OP_BITS-1:0])
          4'd1:    fu_out.aluop <= ALU_MUL; // cpu mul code
          4'd2:    fu_out.aluop <= ALU_DIV;
          default: fu_out.aluop <= alu_op_e'(rs2_val[ALU_OP_BITS-1:0]);
        endcase
      end
      if (issue && load_op1) fu_out.op1 <= rs2_val;
      if (issue && load_op2) fu_out.op2 <= rs2_val;

      // stable bits hold until the coprocessor takes the operand
      if (issue && load_op1) fu_out.csr_in[1] <= 1'b1;
      else if (fu_in.csr_out[0]) fu_out.csr_in[1] <= 1'b0;

      if (issue && load_op2) fu_out.csr_in[2] <= 1'b1;
      else if (fu_in.csr_out[1]) fu_out.csr_in[2] <= 1'b0;

      fu_out.csr_in[0] <= issue && store_op3; // one-cycle pulse
    end
  end

  a_op1_ack: assert property (@(posedge clk) disable iff (reset)
    ($fell(fu_out.csr_in[1]) && !$past(reset)) |-> $past(fu_in.csr_out[0]))
    else $error("op1 stable dropped without coprocessor ack");

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none

module decode_stage import decode_pkg::*; #(
  parameter logic [REG_NO_BITS-1:0] ALUOP_REG   = DEF_ALUOP_REG,
  parameter logic [REG_NO_BITS-1:0] OP1_REG     = DEF_OP1_REG,
  parameter logic [REG_NO_BITS-1:0] OP2_REG     = DEF_OP2_REG,
  parameter logic [REG_NO_BITS-1:0] OP3_REG     = DEF_OP3_REG,
  parameter logic [REG_NO_BITS-1:0] CSR_OUT_REG = DEF_CSR_OUT_REG
) (
  input  logic      clk,
  input  logic      reset,
  input  fe_latch_t fe_latch,
  input  logic      br_mispred,
  input  wb_t       wb,
  input  fu_to_de_t fu_in,
  output logic      stall,
  output de_latch_t de_latch,
  output de_to_fu_t fu_out
);

  dec_info_t       info;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] rs2_val_final;
  logic            wr_reg_final;
  logic            hazard;
  logic            issue;
  de_latch_t       de_next;

  inst_decoder u_dec (
    .fe   (fe_latch),
    .info (info)
  );

  reg_file u_rf (
    .clk     (clk),
    .wb      (wb),
    .rs1     (info.rs1),
    .rs2     (info.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  scoreboard u_sb (
    .clk    (clk),
    .reset  (reset),
    .info   (info),
    .wr_reg (wr_reg_final),
    .issue  (issue),
    .wb     (wb),
    .hazard (hazard)
  );

  alu_port #(
    .ALUOP_REG   (ALUOP_REG),
    .OP1_REG     (OP1_REG),
    .OP2_REG     (OP2_REG),
    .OP3_REG     (OP3_REG),
    .CSR_OUT_REG (CSR_OUT_REG)
  ) u_alu (
    .clk           (clk),
    .reset         (reset),
    .info          (info),
    .issue         (issue),
    .rs2_val       (rs2_val),
    .fu_in         (fu_in),
    .fu_out        (fu_out),
    .rs2_val_final (rs2_val_final),
    .wr_reg_final  (wr_reg_final)
  );

  assign stall = hazard || br_mispred; // fetch holds its latch while high
  assign issue = !stall;

  //////////////////////////////
  // decode latch

  always_comb begin
    de_next.valid   = fe_latch.valid;
    de_next.inst    = fe_latch.inst;
    de_next.pc      = fe_latch.pc;
    de_next.op      = info.op;
    de_next.rs1_val = rs1_val;
    de_next.rs2_val = rs2_val_final;
    de_next.imm     = info.imm;
    de_next.is_br   = info.is_br;
    de_next.is_jmp  = info.is_jmp;
    de_next.rd_mem  = info.rd_mem;
    de_next.wr_mem  = info.wr_mem;
    de_next.wr_reg  = wr_reg_final;
    de_next.rd      = info.rd;
  end

  always_ff @(posedge clk) begin
    if (reset || stall) de_latch <= '0; // bubble
    else de_latch <= de_next;
  end

  a_bubble_after_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> !de_latch.valid)
    else $error("decode latch valid right after a stall");

endmodule

`default_nettype wire

/* tb/tb_decode_stage.sv */
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_WAIT = 20; // cycles a held instruction may stay stalled

  typedef struct packed {
    logic [2:0]      test;
    logic            wait_issue; // hold fetch until stall drops
    logic            valid;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    wb_t             wb;
    fu_to_de_t       fu;
    logic            mispred;
    logic            exp_stall;
    iop_e            exp_op;
    logic [XLEN-1:0] exp_rs1;
    logic [XLEN-1:0] exp_rs2;
    logic [XLEN-1:0] exp_imm;
    logic [4:0]      exp_flags; // is_br is_jmp rd_mem wr_mem wr_reg
    logic            chk_fu;
    logic [2:0]      exp_csr_in;
    alu_op_e         exp_aluop;
    logic [XLEN-1:0] exp_op1;
    logic [XLEN-1:0] exp_op2;
  } step_t;

  logic      clk;
  logic      reset;
  fe_latch_t fe_latch;
  logic      br_mispred;
  wb_t       wb;
  fu_to_de_t fu_in;
  logic      stall;
  de_latch_t de_latch;
  de_to_fu_t fu_out;

  step_t           steps [$];
  logic [XLEN-1:0] ref_regs [32]; // register model
  logic [31:0]     lcg_state;
  string           test_names [6] = '{"decode", "reg_read", "hazard", "mispredict",
                                      "cop_load", "cop_store"};
  int              cur_test;
  int              test_errs;
  int              total_errs;
  int              tests_run;
  int              tests_failed;
  bit              timed_out;

  decode_stage u_dut (
    .clk        (clk),
    .reset      (reset),
    .fe_latch   (fe_latch),
    .br_mispred (br_mispred),
    .wb         (wb),
    .fu_in      (fu_in),
    .stall      (stall),
    .de_latch   (de_latch),
    .fu_out     (fu_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // helpers

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw only
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic step_t make_step(int test, logic [31:0] inst, iop_e op,
                                      logic [31:0] imm, logic [4:0] flags);
    step_t s;
    s           = '0;
    s.test      = 3'(test);
    s.valid     = 1'b1;
    s.inst      = inst;
    s.exp_op    = op;
    s.exp_imm   = imm;
    s.exp_flags = flags;
    return s;
  endfunction

  function automatic step_t idle_step(int test);
    step_t s;
    s      = '0;
    s.test = 3'(test);
    return s;
  endfunction

  // wb of a row is visible to its own reads
  task automatic push_step(step_t s);
    if (s.wb.wr_reg && s.wb.wregno != '0) ref_regs[s.wb.wregno] = s.wb.regval;
    s.exp_rs1 = ref_regs[s.inst[19:15]];
    s.exp_rs2 = ref_regs[s.inst[24:20]];
    if (s.exp_op == IOP_SW && s.inst[24:20] == DEF_OP3_REG) s.exp_rs2 = s.fu.op3;
    if (s.exp_op == IOP_SW && s.inst[24:20] == DEF_CSR_OUT_REG) s.exp_rs2 = {29'b0, s.fu.csr_out};
    // a repeated word is the same fetch slot held by fetch
    if (steps.size() > 0 && steps[$].valid && steps[$].inst == s.inst) s.pc = steps[$].pc;
    else if (s.valid) s.pc = 32'h1000 + 32'(steps.size() * 4);
    steps.push_back(s);
  endtask

  task automatic build_table();
    step_t       s;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    logic [31:0] v5;
    logic [31:0] v6;
    v1 = lcg_next();
    v2 = lcg_next();
    v3 = lcg_next();
    v4 = lcg_next();
    v5 = lcg_next();
    v6 = lcg_next();
    // one word per format, then mul and a junk word
    push_step(make_step(0, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), IOP_ADD, '0, 5'b00001));
    push_step(make_step(0, enc_i(12'hffb, 5'd1, 3'b000, 5'd11, 7'b0010011), IOP_ADDI,
                        32'hffff_fffb, 5'b00001));
    push_step(make_step(0, enc_s(12'hff0, 5'd2, 5'd1), IOP_SW, 32'hffff_fff0, 5'b00010));
    push_step(make_step(0, {20'habcde, 5'd12, 7'b0110111}, IOP_LUI, 32'habcd_e000, 5'b00001));
    push_step(make_step(0, 32'hffdf_f8ef, IOP_JAL, 32'hffff_fffc, 5'b01001)); // jal x17, -4
    push_step(make_step(0, enc_b(13'h1ff8, 5'd2, 5'd1, 3'b000), IOP_BEQ,
                        32'hffff_fff8, 5'b10000));
    push_step(make_step(0, enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd16), IOP_INVALID, '0, '0));
    push_step(make_step(0, 32'hffff_ffff, IOP_INVALID, '0, '0));
    // register read, second write lands in the read cycle
    s = idle_step(1);
    s.wb = {1'b1, 5'd1, v1};
    push_step(s);
    s = make_step(1, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd13), IOP_ADD, '0, 5'b00001);
    s.wb = {1'b1, 5'd2, v2};
    push_step(s);
    // x5 writer, then a reader held until wb retires x5
    push_step(make_step(2, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), IOP_ADD, '0, 5'b00001));
    s = make_step(2, enc_r(7'h00, 5'd1, 5'd5, 3'b000, 5'd14), IOP_ADD, '0, 5'b00001);
    s.exp_stall = 1'b1;
    push_step(s);
    s.wb = {1'b1, 5'd5, v3}; // busy clears one edge later
    push_step(s);
    s.wb         = '0;
    s.exp_stall  = 1'b0;
    s.wait_issue = 1'b1;
    push_step(s);
    s = make_step(3, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd15), IOP_ADD, '0, 5'b00001);
    s.mispred   = 1'b1;
    s.exp_stall = 1'b1;
    push_step(s);
    s.mispred   = 1'b0;
    s.exp_stall = 1'b0;
    push_step(s);
    // coprocessor opcode, op1 and op2 loads
    s = make_step(4, enc_i(12'd4, 5'd0, 3'b010, DEF_ALUOP_REG, 7'b0000011), IOP_LW,
                  32'd4, 5'b00100);
    s.wb        = {1'b1, 5'd4, 32'd1};
    s.chk_fu    = 1'b1;
    s.exp_aluop = ALU_MUL;
    push_step(s);
    s = make_step(4, enc_i(12'd8, 5'd0, 3'b010, DEF_OP1_REG, 7'b0000011), IOP_LW,
                  32'd8, 5'b00100);
    s.wb         = {1'b1, 5'd8, v4};
    s.chk_fu     = 1'b1;
    s.exp_aluop  = ALU_MUL;
    s.exp_csr_in = 3'b010;
    s.exp_op1    = v4;
    push_step(s);
    s = make_step(4, enc_i(12'd9, 5'd0, 3'b010, DEF_OP2_REG, 7'b0000011), IOP_LW,
                  32'd9, 5'b00100);
    s.wb         = {1'b1, 5'd9, v6};
    s.chk_fu     = 1'b1;
    s.exp_aluop  = ALU_MUL;
    s.exp_csr_in = 3'b110;
    s.exp_op1    = v4;
    s.exp_op2    = v6;
    push_step(s);
    s = idle_step(4);
    s.chk_fu     = 1'b1;
    s.exp_aluop  = ALU_MUL;
    s.exp_csr_in = 3'b110;
    s.exp_op1    = v4;
    s.exp_op2    = v6;
    push_step(s);
    s.fu.csr_out = 3'b001; // op1 taken, op2 still pending
    s.exp_csr_in = 3'b100;
    push_step(s);
    // result store from op3
    s = make_step(5, enc_s(12'd0, DEF_OP3_REG, 5'd0), IOP_SW, '0, 5'b00010);
    s.fu.op3     = v5;
    s.chk_fu     = 1'b1;
    s.exp_aluop  = ALU_MUL;
    s.exp_csr_in = 3'b101;
    s.exp_op1    = v4;
    s.exp_op2    = v6;
    push_step(s);
    s = idle_step(5);
    s.chk_fu     = 1'b1;
    s.exp_aluop  = ALU_MUL;
    s.exp_csr_in = 3'b100;
    s.exp_op1    = v4;
    s.exp_op2    = v6;
    push_step(s);
  endtask

  //////////////////////////////
  // drive and check

  task automatic compare_field(string what, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %h, actual %h", test_names[cur_test], what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_outputs(step_t s);
    logic bubble;
    bubble = s.exp_stall || !s.valid; // expect an all zero latch
    compare_field("valid", 32'(!bubble), 32'(de_latch.valid));
    compare_field("pc", bubble ? '0 : s.pc, de_latch.pc);
    compare_field("inst", bubble ? '0 : s.inst, de_latch.inst);
    compare_field("op", bubble ? '0 : 32'(s.exp_op), 32'(de_latch.op));
    compare_field("rs1_val", bubble ? '0 : s.exp_rs1, de_latch.rs1_val);
    compare_field("rs2_val", bubble ? '0 : s.exp_rs2, de_latch.rs2_val);
    compare_field("imm", bubble ? '0 : s.exp_imm, de_latch.imm);
    compare_field("flags", bubble ? '0 : 32'(s.exp_flags),
                  32'({de_latch.is_br, de_latch.is_jmp, de_latch.rd_mem,
                       de_latch.wr_mem, de_latch.wr_reg}));
    compare_field("rd", bubble ? '0 : 32'(s.inst[11:7]), 32'(de_latch.rd));
    if (s.chk_fu) begin
      compare_field("csr_in", 32'(s.exp_csr_in), 32'(fu_out.csr_in));
      compare_field("aluop", 32'(s.exp_aluop), 32'(fu_out.aluop));
      compare_field("op1", s.exp_op1, fu_out.op1);
      compare_field("op2", s.exp_op2, fu_out.op2);
    end
  endtask

  // called 2 ns after a rising edge, returns at the same point one or more cycles on
  task automatic apply_step(step_t s);
    int waited;
    fe_latch.valid = s.valid;
    fe_latch.inst  = s.inst;
    fe_latch.pc    = s.pc;
    wb             = s.wb;
    fu_in          = s.fu;
    br_mispred     = s.mispred;
    #1;
    waited = 0;
    while (s.wait_issue && stall && waited < MAX_WAIT) begin
      @(posedge clk);
      #2;
      wb = '0;
      #1;
      waited++;
    end
    if (s.wait_issue && stall) begin
      $display("timeout: %s instruction still stalled after %0d cycles",
               test_names[cur_test], MAX_WAIT);
      test_errs++;
      timed_out = 1'b1;
    end else if (stall !== s.exp_stall) begin
      $display("FAIL %s stall: expected %b, actual %b", test_names[cur_test],
               s.exp_stall, stall);
      test_errs++;
    end
    @(posedge clk);
    #1;
    check_outputs(s);
    #1;
  endtask

  task automatic report_test();
    if (test_errs == 0) begin
      $display("test %s: ok", test_names[cur_test]);
    end else begin
      $display("test %s: %0d mismatches", test_names[cur_test], test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
    tests_run++;
    test_errs = 0;
  endtask

  initial begin
    reset        = 1'b1;
    fe_latch     = '0;
    br_mispred   = 1'b0;
    wb           = '0;
    fu_in        = '0;
    lcg_state    = 32'ha6d3;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    build_table();
    repeat (3) @(posedge clk);
    #2;
    reset    = 1'b0;
    cur_test = int'(steps[0].test);
    for (int i = 0; i < steps.size(); i++) begin
      if (int'(steps[i].test) != cur_test) begin
        report_test();
        cur_test = int'(steps[i].test);
      end
      apply_step(steps[i]);
      if (timed_out) break;
    end
    report_test();
    $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, total_errs);
    if (total_errs == 0 && !timed_out) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/scoreboard.sv
logic/alu_port.sv
logic/decode_stage.sv
tb/tb_decode_stage.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_decode_stage -f tb.f -o tb_decode_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_decode_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0
